// File: design/video_tx_pkg.sv
// video segment link package
// shared sizes, frame descriptor, link config and FSM state types
package video_tx_pkg;

	localparam int SEG_BYTES   = 16;                         // payload bytes per segment
	localparam int MAX_SEGS    = 8;                          // largest fragment count
	localparam int HDR_BYTES   = 4;                          // txid, aux, seg hi, seg lo
	localparam int GAP_UNIT    = 16;                         // gap cycles per speed step
	localparam int FRAME_BYTES = HDR_BYTES + SEG_BYTES;      // bytes on the wire per frame
	localparam int PREFETCH    = 2;                          // payload read lead, store latency
	localparam int SEG_IDX_W   = $clog2(SEG_BYTES);          // byte index inside a segment
	localparam int SEG_SEL_W   = $clog2(MAX_SEGS);           // segment select into RAM
	localparam int RAM_DEPTH   = MAX_SEGS * SEG_BYTES;       // whole frame buffer
	localparam int RAM_ADDR_W  = SEG_SEL_W + SEG_IDX_W;
	localparam int FRAME_CNT_W = $clog2(FRAME_BYTES + 1);    // counts 0..FRAME_BYTES

	// one frame as the scheduler hands it out
	typedef struct packed {
		logic [15:0] segment_num;
		logic [7:0]  txid;                                   // 1 = first pass
		logic [7:0]  aux;                                    // round counter
	} frame_desc_t;

	typedef struct packed {
		logic [3:0]  seg_count;                              // 1..8
		logic [2:0]  copies;                                 // 1..4
		logic [11:0] gap;                                    // idle cycles before next frame
	} link_cfg_t;

	// address seen by the video source
	typedef struct packed {
		logic [15:0]          segment_num;
		logic [SEG_IDX_W-1:0] byte_idx;
	} video_index_t;

	typedef enum logic [2:0] {
		S_INIT,
		S_FIRST_WAIT,                                        // txid 1, waiting on gap
		S_FIRST_SENT,
		S_REPEAT_WAIT,                                       // txid 2..copies
		S_REPEAT_SENT
	} sched_state_t;

	typedef enum logic [1:0] {
		TX_IDLE,
		TX_HEADER,
		TX_PAYLOAD
	} sender_state_t;

endpackage

// File: design/switch_decode.sv
// switch bank decode
// turns the board DIP switches into segment count, copy count and gap
`timescale 1ns/1ps

module switch_decode (
	input  logic [7:0]              switches, // [7:6] fragment, [5:4] copies, [3:0] speed
	output video_tx_pkg::link_cfg_t cfg
);
	import video_tx_pkg::*;

	logic [1:0]  frag_code;
	logic [4:0]  seg_raw;                     // 1 << code, before clamp
	logic [11:0] speed_steps;

	assign frag_code   = switches[7:6];
	assign seg_raw     = 5'd1 << frag_code;
	assign speed_steps = {8'd0, switches[3:0]} + 12'd1; // 1..16 steps

	always_comb begin
		// clamp against the RAM size
		if (seg_raw > 5'(MAX_SEGS))
			cfg.seg_count = 4'(MAX_SEGS);
		else
			cfg.seg_count = seg_raw[3:0];

		cfg.copies = {1'b0, switches[5:4]} + 3'd1; // 1..4 copies
		cfg.gap    = 12'(speed_steps * GAP_UNIT);  // 16..256 cycles
	end

endmodule

// File: design/send_control.sv
// frame scheduler
// walks aux, txid and segment numbers in order, one send strobe per frame
// paced by the gap timer and held off while the sender is busy
`timescale 1ns/1ps

module send_control (
	input  logic                        clk125MHz,
	input  logic                        RST,
	input  video_tx_pkg::link_cfg_t     cfg,
	input  logic                        busy,          // sender level
	output logic                        start_sending, // one cycle pulse
	output video_tx_pkg::frame_desc_t   desc           // stable until next pulse
);
	import video_tx_pkg::*;

	sched_state_t state;
	logic [11:0]  count;     // idle cycles since busy fell
	logic [15:0]  seg;       // next segment to send
	logic [7:0]   txid;      // current pass
	logic [7:0]   aux;       // current round
	logic         timer_done;
	logic         fire;
	logic         last_seg;
	logic         last_copy;

	assign timer_done = !busy && (count >= cfg.gap);
	assign fire       = timer_done && ((state == S_FIRST_WAIT) || (state == S_REPEAT_WAIT));
	assign last_seg   = seg >= ({12'd0, cfg.seg_count} - 16'd1);
	assign last_copy  = txid >= {5'd0, cfg.copies};

	// gap timer
	always_ff @(posedge clk125MHz) begin
		if (RST) begin
			count <= '0;
		end else if (busy || fire) begin
			count <= '0;               // restart per frame
		end else begin
			count <= count + 12'd1;
		end
	end

	always_ff @(posedge clk125MHz) begin
		if (RST) begin
			state         <= S_INIT;
			seg           <= '0;
			txid          <= 8'd1;
			aux           <= '0;
			start_sending <= 1'b0;
			desc          <= '0;
		end else begin
			start_sending <= 1'b0;     // pulse only on fire
			case (state)
				S_INIT: begin
					seg   <= '0;
					txid  <= 8'd1;
					aux   <= '0;
					state <= S_FIRST_WAIT;
				end

				S_FIRST_WAIT: begin
					if (fire) begin
						start_sending    <= 1'b1;
						desc.segment_num <= seg;
						desc.txid        <= txid;
						desc.aux         <= aux;
						state            <= S_FIRST_SENT;
					end
				end

				S_FIRST_SENT: begin
					if (!last_seg) begin
						seg   <= seg + 16'd1;
						state <= S_FIRST_WAIT;
					end else begin
						seg <= '0;
						if (last_copy) begin // single copy, next round at once
							aux   <= aux + 8'd1;
							state <= S_FIRST_WAIT;
						end else begin
							txid  <= txid + 8'd1;
							state <= S_REPEAT_WAIT;
						end
					end
				end

				S_REPEAT_WAIT: begin
					if (fire) begin
						start_sending    <= 1'b1;
						desc.segment_num <= seg;
						desc.txid        <= txid;
						desc.aux         <= aux;
						state            <= S_REPEAT_SENT;
					end
				end

				S_REPEAT_SENT: begin
					if (!last_seg) begin
						seg   <= seg + 16'd1;
						state <= S_REPEAT_WAIT;
					end else begin
						seg <= '0;
						if (last_copy) begin // round done
							txid  <= 8'd1;
							aux   <= aux + 8'd1;
							state <= S_FIRST_WAIT;
						end else begin
							txid  <= txid + 8'd1;
							state <= S_REPEAT_WAIT;
						end
					end
				end

				default: state <= S_INIT;
			endcase
		end
	end

endmodule

// File: design/segment_store.sv
// segment buffer
// first pass pulls bytes from the video port and keeps a copy in RAM,
// later passes replay the stored copy, both with a 2 cycle read latency
`timescale 1ns/1ps

module segment_store (
	input  logic                                clk125MHz,
	input  logic                                RST,
	input  video_tx_pkg::frame_desc_t           desc,
	input  logic                                start_sending,
	input  logic                                payload_rd,
	input  logic [video_tx_pkg::SEG_IDX_W-1:0]  payload_idx,
	input  logic [7:0]                          video_data,  // 1 cycle after video_rd
	output logic                                video_rd,
	output video_tx_pkg::video_index_t          video_index,
	output logic [7:0]                          payload_byte // 2 cycles after payload_rd
);
	import video_tx_pkg::*;

	logic [7:0]            mem [RAM_DEPTH];
	logic                  first_pass;   // txid 1 frame in progress
	logic                  rd_d1;        // video byte arrives this cycle
	logic [RAM_ADDR_W-1:0] rd_addr;
	logic [RAM_ADDR_W-1:0] wr_addr;
	logic [7:0]            ram_q;        // replay stage 1
	logic [7:0]            byte_q;       // output stage

	assign rd_addr      = {desc.segment_num[SEG_SEL_W-1:0], payload_idx};
	assign video_rd     = payload_rd && first_pass; // same cycle as the sender read
	assign payload_byte = byte_q;

	assign video_index.segment_num = desc.segment_num;
	assign video_index.byte_idx    = payload_idx;

	// pass type, latched per frame
	always_ff @(posedge clk125MHz) begin
		if (RST) begin
			first_pass <= 1'b0;
			rd_d1      <= 1'b0;
		end else begin
			if (start_sending)
				first_pass <= (desc.txid == 8'd1);
			rd_d1 <= video_rd;
		end
	end

	always_ff @(posedge clk125MHz) begin
		wr_addr <= rd_addr;                  // lines up with video_data
		ram_q   <= mem[rd_addr];
		if (rd_d1)
			mem[wr_addr] <= video_data;      // keep first pass copy
		// video byte or stored byte, one register either way
		byte_q <= first_pass ? video_data : ram_q;
	end

endmodule

// File: design/frame_sender.sv
// frame serializer
// sends a 4 byte header then the segment payload, one byte per cycle
// payload reads are issued ahead so the bytes run back to back
`timescale 1ns/1ps

module frame_sender (
	input  logic                                clk125MHz,
	input  logic                                RST,
	input  logic                                start_sending,
	input  video_tx_pkg::frame_desc_t           desc,
	input  logic [7:0]                          payload_byte,
	output logic                                payload_rd,
	output logic [video_tx_pkg::SEG_IDX_W-1:0]  payload_idx,
	output logic [7:0]                          tx_byte,
	output logic                                tx_valid,
	output logic                                tx_last,
	output logic                                busy
);
	import video_tx_pkg::*;

	sender_state_t          state;
	frame_desc_t            hdr;       // descriptor of the frame on the wire
	logic [FRAME_CNT_W-1:0] cnt;       // byte being loaded into tx_byte
	logic [FRAME_CNT_W-1:0] rd_offs;
	logic [7:0]             hdr_byte;
	logic [7:0]             next_byte;

	assign busy    = (state != TX_IDLE); // whole frame incl. last byte
	assign rd_offs = cnt - FRAME_CNT_W'(PREFETCH);

	// read PREFETCH cycles before the byte is loaded
	assign payload_rd  = busy && (cnt >= FRAME_CNT_W'(PREFETCH))
		&& (cnt < FRAME_CNT_W'(PREFETCH + SEG_BYTES));
	assign payload_idx = rd_offs[SEG_IDX_W-1:0];

	always_comb begin
		case (cnt[1:0])
			2'd0:    hdr_byte = hdr.txid;
			2'd1:    hdr_byte = hdr.aux;
			2'd2:    hdr_byte = hdr.segment_num[15:8];
			default: hdr_byte = hdr.segment_num[7:0];
		endcase
		next_byte = (state == TX_HEADER) ? hdr_byte : payload_byte;
	end

	always_ff @(posedge clk125MHz) begin
		if (state == TX_IDLE && start_sending)
			hdr <= desc;
		tx_byte <= next_byte;              // header or payload byte
	end

	always_ff @(posedge clk125MHz) begin
		if (RST) begin
			state    <= TX_IDLE;
			cnt      <= '0;
			tx_valid <= 1'b0;
			tx_last  <= 1'b0;
		end else begin
			case (state)
				TX_IDLE: begin
					tx_valid <= 1'b0;
					tx_last  <= 1'b0;
					if (start_sending) begin
						cnt   <= '0;
						state <= TX_HEADER;
					end
				end

				TX_HEADER: begin
					tx_valid <= 1'b1;
					cnt      <= cnt + FRAME_CNT_W'(1);
					if (cnt == FRAME_CNT_W'(HDR_BYTES - 1))
						state <= TX_PAYLOAD;
				end

				TX_PAYLOAD: begin
					if (cnt == FRAME_CNT_W'(FRAME_BYTES)) begin // last byte is out
						tx_valid <= 1'b0;
						tx_last  <= 1'b0;
						state    <= TX_IDLE;
					end else begin
						tx_valid <= 1'b1;
						tx_last  <= (cnt == FRAME_CNT_W'(FRAME_BYTES - 1));
						cnt      <= cnt + FRAME_CNT_W'(1);
					end
				end

				default: state <= TX_IDLE;
			endcase
		end
	end

endmodule

// File: design/video_tx_top.sv
// video segment link transmitter
// switch decode, frame scheduler, segment buffer and byte serializer
`timescale 1ns/1ps

module video_tx_top (
	input  logic                        clk125MHz,
	input  logic                        RST,
	input  logic [7:0]                  switches,
	input  logic [7:0]                  video_data,
	output logic                        video_rd,
	output video_tx_pkg::video_index_t  video_index,
	output logic [7:0]                  tx_byte,
	output logic                        tx_valid,
	output logic                        tx_last,
	output logic                        busy
);
	import video_tx_pkg::*;

	link_cfg_t              cfg;
	frame_desc_t            desc;
	logic                   start_sending;
	logic                   payload_rd;
	logic [SEG_IDX_W-1:0]   payload_idx;
	logic [7:0]             payload_byte;

	switch_decode switch_decode_i (
		.switches (switches),
		.cfg      (cfg)
	);

	send_control send_control_i (
		.clk125MHz     (clk125MHz),
		.RST           (RST),
		.cfg           (cfg),
		.busy          (busy),          // back-pressure
		.start_sending (start_sending),
		.desc          (desc)
	);

	segment_store segment_store_i (
		.clk125MHz     (clk125MHz),
		.RST           (RST),
		.desc          (desc),
		.start_sending (start_sending),
		.payload_rd    (payload_rd),
		.payload_idx   (payload_idx),
		.video_data    (video_data),
		.video_rd      (video_rd),
		.video_index   (video_index),
		.payload_byte  (payload_byte)
	);

	frame_sender frame_sender_i (
		.clk125MHz     (clk125MHz),
		.RST           (RST),
		.start_sending (start_sending),
		.desc          (desc),
		.payload_byte  (payload_byte),
		.payload_rd    (payload_rd),
		.payload_idx   (payload_idx),
		.tx_byte       (tx_byte),
		.tx_valid      (tx_valid),
		.tx_last       (tx_last),
		.busy          (busy)
	);

endmodule

// File: tests/video_tx_tb.sv
// video link testbench
// runs switch rows through the DUT, models the video source, checks every frame
`timescale 1ns/1ps

module video_tx_tb;
	import video_tx_pkg::*;

	typedef struct packed {
		logic [7:0] switches;
		logic [7:0] frames;                   // frames to check in this row
	} stim_row_t;

	logic         clk125MHz;
	logic         RST;
	logic [7:0]   switches;
	logic [7:0]   video_data = 8'h00;
	logic         video_rd;
	video_index_t video_index;
	logic [7:0]   tx_byte;
	logic         tx_valid;
	logic         tx_last;
	logic         busy;

	stim_row_t    stim_rows [$];
	logic [7:0]   ref_mem [int];              // bytes handed out, keyed by aux/seg/byte
	logic [7:0]   frame_q [$];                // bytes of the frame just received
	logic [31:0]  lcg_state = 32'he715_5a24;
	logic [7:0]   vid_next;
	logic         vid_req = 1'b0;
	frame_desc_t  exp_desc;                   // predicted next frame
	int           errors;
	int           model_errors = 0;           // raised by the video model
	int           timeouts;
	int           checks;

	initial clk125MHz = 1'b0;
	always #4 clk125MHz = ~clk125MHz;         // 125 MHz

	video_tx_top DUT (
		.clk125MHz   (clk125MHz),
		.RST         (RST),
		.switches    (switches),
		.video_data  (video_data),
		.video_rd    (video_rd),
		.video_index (video_index),
		.tx_byte     (tx_byte),
		.tx_valid    (tx_valid),
		.tx_last     (tx_last),
		.busy        (busy)
	);

	function automatic logic [31:0] lcg_step(input logic [31:0] s);
		return s * 32'd1664525 + 32'd1013904223;
	endfunction

	function automatic int ref_key(input logic [7:0] aux, input logic [15:0] seg, input int idx);
		return (int'(aux) << 20) + (int'(seg) << 4) + idx;
	endfunction

	// video source, sampled mid-cycle, answers on the next cycle
	always @(negedge clk125MHz) begin
		vid_req <= 1'b0;
		if (!RST && video_rd) begin
			lcg_state = lcg_step(lcg_state);  // one step per read
			vid_next <= lcg_state[23:16];
			vid_req  <= 1'b1;
			ref_mem[ref_key(exp_desc.aux, video_index.segment_num,
				int'(video_index.byte_idx))] = lcg_state[23:16];
			if (exp_desc.txid != 8'd1) begin
				model_errors++;
				$display("video_rd was raised during a repeat pass (txid %0d)", exp_desc.txid);
			end
			if (video_index.segment_num !== exp_desc.segment_num) begin
				model_errors++;
				$display("[ERROR] video_index.segment_num got 0x%h expected 0x%h",
					video_index.segment_num, exp_desc.segment_num);
			end
		end
	end

	always @(posedge clk125MHz) begin
		if (vid_req) begin
			#1;
			video_data = vid_next;
		end
	end

	task automatic check_desc(input frame_desc_t got, input frame_desc_t exp);
		checks++;
		if (got.segment_num !== exp.segment_num) begin
			errors++;
			$display("[ERROR] segment_num got 0x%h expected 0x%h", got.segment_num, exp.segment_num);
		end
		if (got.txid !== exp.txid) begin
			errors++;
			$display("[ERROR] txid got 0x%h expected 0x%h", got.txid, exp.txid);
		end
		if (got.aux !== exp.aux) begin
			errors++;
			$display("[ERROR] aux got 0x%h expected 0x%h", got.aux, exp.aux);
		end
	endtask

	task automatic check_byte(input logic [7:0] got, input int idx, input logic [7:0] exp);
		checks++;
		if (got !== exp) begin
			errors++;
			$display("[ERROR] payload byte %0d got 0x%h expected 0x%h", idx, got, exp);
		end
	endtask

	task automatic check_gap(input logic [31:0] measured, input logic [31:0] minimum);
		checks++;
		if (measured < minimum) begin
			errors++;
			$display("[ERROR] busy idle cycles got 0x%h expected at least 0x%h", measured, minimum);
		end
	endtask

	task automatic check_flag(input string name, input logic got, input logic exp);
		checks++;
		if (got !== exp) begin
			errors++;
			$display("[ERROR] %s got 0x%h expected 0x%h", name, got, exp);
		end
	endtask

	task automatic check_count(input string name, input int got, input int exp);
		checks++;
		if (got != exp) begin
			errors++;
			$display("[ERROR] %s got 0x%h expected 0x%h", name, got, exp);
		end
	endtask

	task automatic apply_reset(input logic [7:0] sw);
		@(posedge clk125MHz);
		#1;
		RST      = 1'b1;
		switches = sw;                        // only changed under reset
		repeat (5) @(posedge clk125MHz);
		#1;
		RST = 1'b0;
	endtask

	// waits for busy, link must stay quiet meanwhile
	task automatic wait_frame_start(input int limit, output logic [31:0] idle, output logic ok);
		int n;
		idle = 0;
		ok   = 1'b0;
		for (n = 0; n < limit; n++) begin
			@(negedge clk125MHz);
			if (busy) begin
				ok = 1'b1;
				break;
			end
			idle++;
			if (tx_valid || tx_last || video_rd) begin
				errors++;
				$display("[ERROR] tx_valid 0x%h tx_last 0x%h video_rd 0x%h expected 0x0 while idle",
					tx_valid, tx_last, video_rd);
			end
		end
	endtask

	// gathers valid bytes until busy falls
	task automatic collect_frame(input int limit, output int nbytes, output logic ok);
		int n;
		nbytes = 0;
		ok     = 1'b0;
		frame_q.delete();
		for (n = 0; n < limit; n++) begin
			@(negedge clk125MHz);
			if (!busy) begin
				ok = 1'b1;
				break;
			end
			if (tx_valid) begin
				frame_q.push_back(tx_byte);
				check_flag("tx_last", tx_last, (nbytes == FRAME_BYTES - 1)); // last byte only
				nbytes++;
			end else begin
				check_flag("tx_last", tx_last, 1'b0);
			end
		end
	endtask

	// segment first, then txid, then aux
	task automatic next_frame(input int segs, input int copies);
		if (int'(exp_desc.segment_num) < segs - 1) begin
			exp_desc.segment_num = exp_desc.segment_num + 16'd1;
		end else begin
			exp_desc.segment_num = '0;
			if (int'(exp_desc.txid) < copies) begin
				exp_desc.txid = exp_desc.txid + 8'd1;
			end else begin
				exp_desc.txid = 8'd1;
				exp_desc.aux  = exp_desc.aux + 8'd1; // round done
			end
		end
	endtask

	initial begin
		stim_row_t   row;
		frame_desc_t got_desc;
		logic [31:0] idle;
		logic [31:0] min_gap;
		logic        ok;
		int          nbytes;
		int          segs;
		int          copies;
		int          gap;
		int          limit;
		int          r;
		int          f;
		int          i;
		int          key;

		RST      = 1'b1;
		switches = 8'h00;
		exp_desc = '0;
		errors   = 0;
		timeouts = 0;
		checks   = 0;

		stim_rows.push_back({8'h00, 8'd4});  // 1 seg, 1 copy, fastest
		stim_rows.push_back({8'h63, 8'd8});  // 2 segs, 3 copies, speed 3
		stim_rows.push_back({8'hD1, 8'd18}); // code 3 clamps to 8 segs, 2 copies
		stim_rows.push_back({8'hBF, 8'd18}); // 4 segs, 4 copies, slowest
		stim_rows.push_back({8'hC7, 8'd10}); // 8 segs, 1 copy, speed 7

		for (r = 0; r < stim_rows.size(); r++) begin
			row     = stim_rows[r];
			segs    = (row.switches[7:6] == 2'd3) ? MAX_SEGS : (1 << row.switches[7:6]);
			copies  = int'(row.switches[5:4]) + 1;
			gap     = (int'(row.switches[3:0]) + 1) * GAP_UNIT;
			min_gap = 32'(gap + 1);
			limit   = 4 * (gap + FRAME_BYTES + 8); // several frame periods
			ref_mem.delete();
			exp_desc      = '0;
			exp_desc.txid = 8'd1;
			apply_reset(row.switches);
			for (f = 0; f < int'(row.frames); f++) begin
				wait_frame_start(limit, idle, ok);
				if (!ok) begin
					timeouts++;
					$display("frame %0d of row %0d (aux %0d txid %0d segment %0d) never started",
						f, r, exp_desc.aux, exp_desc.txid, exp_desc.segment_num);
					break;
				end
				if (f > 0)
					check_gap(idle + 32'd1, min_gap); // first idle cycle seen by collect
				collect_frame(limit, nbytes, ok);
				if (!ok) begin
					timeouts++;
					$display("frame %0d of row %0d kept busy high and never finished", f, r);
					break;
				end
				check_count("tx_valid byte count", nbytes, FRAME_BYTES);
				if (frame_q.size() == FRAME_BYTES) begin
					got_desc.txid        = frame_q[0];
					got_desc.aux         = frame_q[1];
					got_desc.segment_num = {frame_q[2], frame_q[3]};
					check_desc(got_desc, exp_desc);
					for (i = 0; i < SEG_BYTES; i++) begin
						key = ref_key(exp_desc.aux, exp_desc.segment_num, i);
						if (!ref_mem.exists(key)) begin
							errors++;
							$display("no video byte was supplied for aux %0d segment %0d byte %0d",
								exp_desc.aux, exp_desc.segment_num, i);
						end else begin
							check_byte(frame_q[HDR_BYTES + i], i, ref_mem[key]);
						end
					end
				end
				next_frame(segs, copies);
			end
		end

		errors = errors + model_errors;
		$display("checks %0d, errors %0d, timeouts %0d", checks, errors, timeouts);
		if (errors == 0 && timeouts == 0)
			$display("Testbench passed");
		else
			$display("Testbench failed");
		$finish;
	end

endmodule

// File: video_tx_top.f
design/video_tx_pkg.sv
design/switch_decode.sv
design/send_control.sv
design/segment_store.sv
design/frame_sender.sv
design/video_tx_top.sv
tests/video_tx_tb.sv

// File: Makefile
# Verilator build for the video link transmitter

VERILATOR  := verilator
TOP        := video_tx_tb
FILELIST   := video_tx_top.f
OBJ_DIR    := obj_dir
COMMON     := --timing --timescale 1ns/1ps
LINT_FLAGS := --lint-only $(COMMON)
SIM_FLAGS  := --binary $(COMMON) -j 0
PASS_MSG   := Testbench passed

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

$(OBJ_DIR)/V$(TOP): $(shell cat $(FILELIST)) $(FILELIST)
	$(VERILATOR) $(SIM_FLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

sim: $(OBJ_DIR)/V$(TOP)
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)
